// File: hw/rng_pkg.sv
// one sample in flight at a time; no reseed at run time; output carries no statistical guarantee
package rng_pkg;

    // ====================
    // widths
    // ====================

    // shift registers, operands and output byte
    localparam int unsigned RND_W = 8;

    // signed Booth product
    localparam int unsigned PROD_W = 2 * RND_W;

    // iteration counter of the Booth unit
    localparam int unsigned MUL_ITER_W = $clog2(RND_W);

    // ====================
    // types
    // ====================

    typedef logic [RND_W-1:0] rnd_t;

    typedef logic signed [PROD_W-1:0] prod_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    // ====================
    // reset values
    // ====================

    // seeds must not both be zero, the pair would never leave zero
    localparam rnd_t SEED_A = 8'hF0;
    localparam rnd_t SEED_B = 8'h0F;

    // credits held after reset
    localparam int unsigned CREDITS = 4;

    // counter must hold CREDITS itself
    localparam int unsigned CREDIT_W = 3;

endpackage

// File: hw/rng_mul_if.sv
// start is legal only while busy is low; done is a single-cycle pulse with product valid alongside
`timescale 1ns/1ps

interface rng_mul_if (
    input logic clk
);
    import rng_pkg::*;

    logic  start;
    rnd_t  mcand;
    rnd_t  mplier;
    logic  busy;
    logic  done;
    prod_t product;

    // shift registers and operand forming
    modport seed (input start, output mcand, output mplier);

    // Booth unit
    modport mul (
        input  start,
        input  mcand,
        input  mplier,
        output busy,
        output done,
        output product
    );

    // credit and output stage
    modport ctrl (output start, input busy, input done, input product);

endinterface

// File: hw/rng_seed_lfsr.sv
// both registers step only on an accepted start; seeds come from rng_pkg and must not both be zero
`timescale 1ns/1ps

module rng_seed_lfsr (
    input logic  clk,
    input logic  rst,
    rng_mul_if.seed m
);
    import rng_pkg::*;

    rnd_t state_a;
    rnd_t state_b;
    rnd_t next_a;
    rnd_t next_b;
    logic fb_a;
    logic fb_b;

    // ====================
    // cross feedback
    // ====================

    // each register takes the other's top bit
    assign fb_a = state_b[RND_W-1] ^ state_a[0];
    assign fb_b = state_a[RND_W-1] ^ state_b[0];

    assign next_a = {state_a[RND_W-2:0], fb_a};
    assign next_b = {state_b[RND_W-2:0], fb_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_a <= SEED_A;
            state_b <= SEED_B;
        end else if (m.start) begin
            state_a <= next_a;
            state_b <= next_b;
        end
    end

    // ====================
    // operands
    // ====================

    // taken from the states before the step
    assign m.mcand  = state_a ^ state_b;
    assign m.mplier = state_a + state_b;

    // the step is invertible, so a nonzero seed pair stays nonzero
    states_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        !((state_a == '0) && (state_b == '0))
    );

endmodule

// File: hw/rng_booth_mul.sv
// radix-2 Booth, signed operands, eight iterations per product; start must not arrive while busy
`timescale 1ns/1ps

module rng_booth_mul (
    input logic clk,
    input logic rst,
    rng_mul_if.mul m
);
    import rng_pkg::*;

    mul_state_e state;

    // {upper half, multiplier, extra low bit}
    logic [PROD_W:0]         acc;
    logic [PROD_W:0]         acc_next;
    rnd_t                    mcand_q;
    logic [MUL_ITER_W-1:0]   iter;
    prod_t                   product_q;

    logic signed [RND_W:0]   upper_ext;
    logic signed [RND_W:0]   mcand_ext;
    logic signed [RND_W:0]   sum_ext;
    logic                    last_iter;

    // ====================
    // one Booth step
    // ====================

    // add or subtract one bit wider, so a multiplicand of -128 cannot overflow
    always_comb begin
        upper_ext = {acc[PROD_W], acc[PROD_W:RND_W+1]};
        mcand_ext = {mcand_q[RND_W-1], mcand_q};
        case (acc[1:0])
            2'b01: begin
                sum_ext = upper_ext + mcand_ext;
            end
            2'b10: begin
                sum_ext = upper_ext - mcand_ext;
            end
            default: begin
                sum_ext = upper_ext;
            end
        endcase
    end

    // arithmetic shift right after the add, the wide sign bit fills the top
    assign acc_next  = {sum_ext, acc[RND_W:1]};
    assign last_iter = (iter == MUL_ITER_W'(RND_W - 1));

    // ====================
    // control
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MUL_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                MUL_IDLE, MUL_DONE: begin
                    iter <= '0;
                    if (m.start) begin
                        state <= MUL_BUSY;
                    end else begin
                        state <= MUL_IDLE;
                    end
                end
                MUL_BUSY: begin
                    iter <= iter + 1'b1;
                    if (last_iter) begin
                        state <= MUL_DONE;
                    end
                end
                default: begin
                    state <= MUL_IDLE;
                end
            endcase
        end
    end

    // ====================
    // datapath
    // ====================

    always_ff @(posedge clk) begin
        if ((state != MUL_BUSY) && m.start) begin
            mcand_q <= m.mcand;
            acc     <= {{RND_W{1'b0}}, m.mplier, 1'b0};
        end else if (state == MUL_BUSY) begin
            acc <= acc_next;
        end
    end

    // product registered together with the move to done
    always_ff @(posedge clk) begin
        if ((state == MUL_BUSY) && last_iter) begin
            product_q <= prod_t'(acc_next[PROD_W:1]);
        end
    end

    assign m.busy    = (state == MUL_BUSY);
    assign m.done    = (state == MUL_DONE);
    assign m.product = product_q;

    // issue logic lives in the output stage
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        m.start |-> !m.busy
    );

endmodule

// File: hw/rng_credit_out.sv
// consumer returns one credit per byte as a single pulse, never more than CREDITS outstanding
`timescale 1ns/1ps

module rng_credit_out (
    input  logic          clk,
    input  logic          rst,
    input  logic          en,
    input  logic          credit_return,
    output logic          rnd_valid,
    output rng_pkg::rnd_t rnd_data,
    rng_mul_if.ctrl       m
);
    import rng_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                have_credit;

    // ====================
    // sample issue
    // ====================

    assign have_credit = (credits != '0);

    // busy holds off a second sample until the product is out
    assign m.start = en && have_credit && !m.busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(CREDITS);
        end else begin
            case ({m.start, credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

    // ====================
    // output register
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd_valid <= 1'b0;
        end else begin
            rnd_valid <= m.done;
        end
    end

    // low byte only
    always_ff @(posedge clk) begin
        if (m.done) begin
            rnd_data <= m.product[RND_W-1:0];
        end
    end

    credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(CREDITS)
    );

    // a full count means the consumer has nothing to return
    no_return_when_full: assert property (
        @(posedge clk) disable iff (rst)
        credit_return |-> (credits != CREDIT_W'(CREDITS))
    );

    valid_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        rnd_valid |=> !rnd_valid
    );

endmodule

// File: hw/rng_cross_top.sv
// rnd_valid rises nine cycles after a sample starts; credit_return must stay a single pulse per byte
`timescale 1ns/1ps

module rng_cross_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          en,
    input  logic          credit_return,
    output logic          rnd_valid,
    output rng_pkg::rnd_t rnd_data
);

    // ====================
    // internal bus
    // ====================

    rng_mul_if mul_if (
        .clk (clk)
    );

    // ====================
    // blocks
    // ====================

    // operands from the current register states
    rng_seed_lfsr seed_i (
        .clk (clk),
        .rst (rst),
        .m   (mul_if.seed)
    );

    rng_booth_mul mul_i (
        .clk (clk),
        .rst (rst),
        .m   (mul_if.mul)
    );

    // credits, sample issue and output byte
    rng_credit_out out_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .credit_return (credit_return),
        .rnd_valid     (rnd_valid),
        .rnd_data      (rnd_data),
        .m             (mul_if.ctrl)
    );

endmodule

// File: test/rng_cross_tb.sv
// checks the byte sequence from the package seeds; bytes shown while rst is high are discarded
`timescale 1ns/1ps

module rng_cross_tb;
    import rng_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int N_SEQ         = 40;
    localparam int N_RESUME      = 6;
    localparam int N_PAUSE       = 20;
    localparam int N_RESTART     = 12;
    localparam int IDLE_CYCLES   = 100;
    localparam int DRAIN_CYCLES  = 30;
    localparam int SETTLE_CYCLES = 12;
    localparam int TOTAL_SAMPLES = N_SEQ + CREDITS + N_RESUME + N_PAUSE + CREDITS + N_RESTART;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_SAMPLES + 500;

    logic   clk;
    logic   rst;
    logic   en;
    logic   credit_return;
    logic   rnd_valid;
    rnd_t   rnd_data;

    // reference model state
    rnd_t   ref_a;
    rnd_t   ref_b;

    int     out_count;
    int     owed;
    bit     auto_return;
    logic   send_credit;
    int     mismatch_errors;
    int     other_errors;
    string  test_name;
    integer seed;

    rng_cross_top rng_cross_top_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .credit_return (credit_return),
        .rnd_valid     (rnd_valid),
        .rnd_data      (rnd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // reference model
    // ====================

    function automatic rnd_t cross_shift(input rnd_t self, input rnd_t other);
        return {self[RND_W-2:0], other[RND_W-1] ^ self[0]};
    endfunction

    // operands from the states before the step
    function automatic rnd_t next_expected();
        rnd_t  x;
        rnd_t  s;
        rnd_t  na;
        rnd_t  nb;
        prod_t p;
        x = ref_a ^ ref_b;
        s = ref_a + ref_b;
        p = $signed(x) * $signed(s);
        na = cross_shift(ref_a, ref_b);
        nb = cross_shift(ref_b, ref_a);
        ref_a = na;
        ref_b = nb;
        return p[RND_W-1:0];
    endfunction

    function automatic int rand_cycles(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    // ====================
    // checks
    // ====================

    task automatic check_rnd(input string name, input rnd_t expected, input rnd_t actual);
        if (expected !== actual) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            mismatch_errors++;
            $display("MISMATCH %s count: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // consumer side, sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (rnd_valid === 1'b1) begin
                check_rnd(test_name, next_expected(), rnd_data);
                out_count++;
                if (auto_return) begin
                    owed++;
                end
            end else if (rnd_valid !== 1'b0) begin
                other_errors++;
                $display("rnd_valid is unknown during test %s", test_name);
            end
        end
    end

    // one return pulse per owed credit
    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            if (rst !== 1'b0) begin
                owed = 0;
                send_credit = 1'b0;
            end else if (owed > 0) begin
                owed = owed - 1;
                send_credit = 1'b1;
            end else begin
                send_credit = 1'b0;
            end
            #DRIVE_DLY;
            credit_return = send_credit;
        end
    end

    // ====================
    // stimulus helpers
    // ====================

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic set_en(input logic v);
        @(posedge clk);
        #DRIVE_DLY;
        en = v;
    endtask

    task automatic set_auto_return(input bit v);
        @(posedge clk);
        #DRIVE_DLY;
        auto_return = v;
    endtask

    task automatic return_credits(input int n);
        @(posedge clk);
        #DRIVE_DLY;
        owed = owed + n;
    endtask

    task automatic wait_outputs(input int target);
        while (out_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic apply_reset();
        int i;
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        en = 1'b0;
        auto_return = 1'b0;
        ref_a = SEED_A;
        ref_b = SEED_B;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            // a byte from before the reset may still show in the first cycle
            if ((i > 0) && (rnd_valid !== 1'b0)) begin
                other_errors++;
                $display("rnd_valid high while reset is held in test %s", test_name);
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
    endtask

    // ====================
    // tests
    // ====================

    initial begin
        int base;
        int i;
        rst = 1'b1;
        en = 1'b0;
        auto_return = 1'b0;
        owed = 0;
        out_count = 0;
        mismatch_errors = 0;
        other_errors = 0;
        seed = 39;
        ref_a = SEED_A;
        ref_b = SEED_B;

        test_name = "reset";
        apply_reset();
        repeat (50) begin
            @(negedge clk);
            if (rnd_valid !== 1'b0) begin
                other_errors++;
                $display("rnd_valid not low after reset with en low");
            end
        end
        check_count(test_name, 0, out_count);

        test_name = "sequence";
        base = out_count;
        set_en(1'b1);
        auto_return = 1'b1;
        wait_outputs(base + N_SEQ);
        set_en(1'b0);
        wait_cycles(DRAIN_CYCLES);
        set_auto_return(1'b0);

        test_name = "credit limit";
        base = out_count;
        set_en(1'b1);
        wait_outputs(base + CREDITS);
        wait_cycles(IDLE_CYCLES);
        check_count(test_name, CREDITS, out_count - base);

        test_name = "resume";
        base = out_count;
        for (i = 0; i < N_RESUME; i++) begin
            wait_cycles(rand_cycles(1, 15));
            return_credits(1);
            wait_outputs(base + i + 1);
            wait_cycles(SETTLE_CYCLES);
            check_count(test_name, i + 1, out_count - base);
        end

        // the credits spent in the credit limit test come back here
        test_name = "enable pause";
        base = out_count;
        set_auto_return(1'b1);
        return_credits(CREDITS);
        while (out_count < base + N_PAUSE) begin
            set_en(1'b0);
            wait_cycles(rand_cycles(1, 10));
            set_en(1'b1);
            wait_cycles(rand_cycles(1, 16));
        end
        set_en(1'b0);
        wait_cycles(DRAIN_CYCLES);

        test_name = "reset mid-run";
        set_en(1'b1);
        wait_cycles(rand_cycles(20, 40));
        apply_reset();
        base = out_count;
        set_en(1'b1);
        wait_outputs(base + CREDITS);
        wait_cycles(IDLE_CYCLES);
        check_count(test_name, CREDITS, out_count - base);
        set_auto_return(1'b1);
        return_credits(CREDITS);
        wait_outputs(base + CREDITS + N_RESTART);
        set_en(1'b0);
        wait_cycles(DRAIN_CYCLES);

        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if ((mismatch_errors == 0) && (other_errors == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // ====================
    // watchdog
    // ====================

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: test %s did not finish in %0d cycles", test_name, WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: rng_cross.f
hw/rng_pkg.sv
hw/rng_mul_if.sv
hw/rng_seed_lfsr.sv
hw/rng_booth_mul.sv
hw/rng_credit_out.sv
hw/rng_cross_top.sv
test/rng_cross_tb.sv

// File: Bender.yml
package:
  name: rng_cross

sources:
  - hw/rng_pkg.sv
  - hw/rng_mul_if.sv
  - hw/rng_seed_lfsr.sv
  - hw/rng_booth_mul.sv
  - hw/rng_credit_out.sv
  - hw/rng_cross_top.sv
  - target: test
    files:
      - test/rng_cross_tb.sv
